// ==== src/sonata_config.svh ====
/*
 * Board I/O shell configuration
 * Widths and counts shared by the packages and the RTL
 */
`ifndef SONATA_CONFIG_SVH
`define SONATA_CONFIG_SVH

// Reset counter width, full count is 2**RST_CNT_WIDTH clocks
`define RST_CNT_WIDTH 8

// GPIO word width on the system side
`define GP_WIDTH 32

// Two PMOD headers of 8 pins each
`define PMOD_WIDTH 16

// One chip select per SPI controller
`define SPI_NUM 3

// Flops in each input synchronizer
`define SYNC_STAGES 2

`endif

// ==== src/board_pins_pkg.sv ====
/*
 * Board pin groups
 * Pin-side views of switches, serial inputs, outputs and PMOD headers
 */
`include "sonata_config.svh"

package board_pins_pkg;

  // Raw switches, active low, pulled up on the board
  typedef struct packed {
    logic [2:0] sel;  // Software select switches
    logic [7:0] usr;  // User switches
    logic [4:0] nav;  // Joystick
  } sw_t;

  // Input-only pins
  typedef struct packed {
    logic ser0_rx;
    logic ser1_rx;
    logic rs232_rx;
    logic appspi_cipo;  // Flash data in
    logic ethmac_cipo;
  } in_pins_t;

  // Output-only pins, also used for the enable word
  typedef struct packed {
    logic ser0_tx;
    logic ser1_tx;
    logic rs232_tx;
    logic appspi_clk;
    logic appspi_copi;
    logic lcd_clk;
    logic lcd_copi;
    logic ethmac_sclk;
    logic ethmac_copi;
  } out_pins_t;

  // PMOD0 in the low byte, PMOD1 in the high byte
  typedef logic [`PMOD_WIDTH-1:0] pmod_t;

endpackage

// ==== src/sys_io_pkg.sv ====
/*
 * System-side I/O words
 * GPIO input and output layout and the SPI chip selects
 */
`include "sonata_config.svh"

package sys_io_pkg;

  // GPIO input, switches active high
  typedef struct packed {
    logic [`GP_WIDTH-17:0] pad;  // Always zero
    logic [2:0]            sel;
    logic [7:0]            usr;
    logic [4:0]            nav;
  } gp_in_t;

  // GPIO output, board controls in the low bits
  typedef struct packed {
    logic [`GP_WIDTH-13:0] spare;
    logic                  ethmac_rst;
    logic [7:0]            usr_led;
    logic                  lcd_backlight;
    logic                  lcd_dc;
    logic                  lcd_rst;
  } gp_out_t;

  // Chip selects, active low, one per controller
  typedef struct packed {
    logic ethmac;  // Bit 2
    logic lcd;     // Bit 1
    logic appspi;  // Bit 0
  } spi_cs_t;

endpackage

// ==== src/rst_ctrl.sv ====
/*
 * System reset generator
 * Holds the system in reset until the PLL has been locked for a full count
 */
`timescale 1ns/1ps
`include "sonata_config.svh"

module rst_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,       // Board button
  input  logic pll_locked_i,
  output logic rst_sys_n_o
);

  logic [`RST_CNT_WIDTH-1:0] cnt_q;
  logic                      cnt_done;
  logic                      rst_sys_n_q;

  assign cnt_done = &cnt_q;

  // Count restarts whenever lock is lost
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (!pll_locked_i) begin
      cnt_q <= '0;
    end else if (!cnt_done) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Lock qualifies the release too, so a lost lock
  // takes the system down on the very next edge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_sys_n_q <= 1'b0;
    end else begin
      rst_sys_n_q <= pll_locked_i & cnt_done;
    end
  end

  assign rst_sys_n_o = rst_sys_n_q;  // Glitch-free, straight from a flop

endmodule

// ==== src/pin_sync.sv ====
/*
 * Input synchronizer
 * Flop chain for asynchronous board inputs of any payload type
 */
`timescale 1ns/1ps
`include "sonata_config.svh"

module pin_sync #(
  parameter type sync_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  sync_t d_i,
  output sync_t q_o
);

  sync_t stage_q [`SYNC_STAGES];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_q <= '{default: '0};
    end else begin
      stage_q[0] <= d_i;  // First flop may go metastable
      for (int i = 1; i < `SYNC_STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[`SYNC_STAGES-1];

endmodule

// ==== src/in_pinmux.sv ====
/*
 * Input pin conditioning
 * Synchronizes switches and serial inputs, builds the GPIO input word
 */
`timescale 1ns/1ps

module in_pinmux (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  board_pins_pkg::sw_t    sw_i,
  input  board_pins_pkg::in_pins_t in_pins_i,
  output sys_io_pkg::gp_in_t     gp_i_o,
  output board_pins_pkg::in_pins_t in_from_pins_o
);

  board_pins_pkg::sw_t sw_on_n;  // Switches, 1 means on
  board_pins_pkg::sw_t sw_on;

  // Switches pull to ground when on. The inversion sits ahead of the
  // synchronizer so that the chain resets to "all off"
  assign sw_on_n = board_pins_pkg::sw_t'(~sw_i);

  pin_sync #(
    .sync_t (board_pins_pkg::sw_t)
  ) u_sw_sync (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .d_i     (sw_on_n),
    .q_o     (sw_on)
  );

  pin_sync #(
    .sync_t (board_pins_pkg::in_pins_t)
  ) u_in_sync (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .d_i     (in_pins_i),
    .q_o     (in_from_pins_o)
  );

  // Pack into the GPIO word, upper half unused
  assign gp_i_o = '{
    pad: '0,
    sel: sw_on.sel,
    usr: sw_on.usr,
    nav: sw_on.nav
  };

endmodule

// ==== src/out_pinmux.sv ====
/*
 * Output pin flops
 * Gates disabled pins low, unpacks GPIO controls and routes chip selects
 */
`timescale 1ns/1ps
`include "sonata_config.svh"

module out_pinmux (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  board_pins_pkg::out_pins_t out_to_pins_i,
  input  board_pins_pkg::out_pins_t out_to_pins_en_i,
  input  sys_io_pkg::gp_out_t       gp_o_i,
  input  sys_io_pkg::spi_cs_t       spi_cs_i,
  output board_pins_pkg::out_pins_t out_pins_o,
  output logic [7:0]                usr_led_o,
  output logic                      lcd_rst_o,
  output logic                      lcd_dc_o,
  output logic                      lcd_backlight_o,
  output logic                      ethmac_rst_o,
  output logic                      appspi_cs_o,
  output logic                      lcd_cs_o,
  output logic                      ethmac_cs_o
);

  board_pins_pkg::out_pins_t pins_gated;
  logic [`SPI_NUM-1:0]       cs_q;  // Same bit order as spi_cs_t

  // Disabled pins are pulled low rather than left floating
  assign pins_gated = board_pins_pkg::out_pins_t'(out_to_pins_i & out_to_pins_en_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_pins_o      <= '0;
      usr_led_o       <= '0;
      lcd_rst_o       <= 1'b0;
      lcd_dc_o        <= 1'b0;
      lcd_backlight_o <= 1'b0;
      ethmac_rst_o    <= 1'b0;
    end else begin
      out_pins_o      <= pins_gated;
      usr_led_o       <= gp_o_i.usr_led;
      lcd_rst_o       <= gp_o_i.lcd_rst;
      lcd_dc_o        <= gp_o_i.lcd_dc;
      lcd_backlight_o <= gp_o_i.lcd_backlight;
      ethmac_rst_o    <= gp_o_i.ethmac_rst;
    end
  end

  // Chip selects idle high, so no device is selected in reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cs_q <= '1;
    end else begin
      cs_q <= spi_cs_i;
    end
  end

  assign appspi_cs_o = cs_q[0];  // Flash
  assign lcd_cs_o    = cs_q[1];
  assign ethmac_cs_o = cs_q[2];

endmodule

// ==== src/padring.sv ====
/*
 * PMOD pad ring
 * Registered tristate drivers with synchronized read-back
 */
`timescale 1ns/1ps

module padring (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  board_pins_pkg::pmod_t inout_to_pins_i,
  input  board_pins_pkg::pmod_t inout_to_pins_en_i,
  output board_pins_pkg::pmod_t inout_from_pins_o,
  inout  wire board_pins_pkg::pmod_t pmod_io
);

  board_pins_pkg::pmod_t to_pins_q;
  board_pins_pkg::pmod_t en_q;

  // Enables reset low so every pad starts as an input
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q      <= '0;
      to_pins_q <= '0;
    end else begin
      en_q      <= inout_to_pins_en_i;
      to_pins_q <= inout_to_pins_i;
    end
  end

  for (genvar i = 0; i < $bits(board_pins_pkg::pmod_t); i++) begin : g_pad
    assign pmod_io[i] = en_q[i] ? to_pins_q[i] : 1'bz;
  end

  // Pins can be driven by whatever is plugged into the header
  pin_sync #(
    .sync_t (board_pins_pkg::pmod_t)
  ) u_pmod_sync (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .d_i     (pmod_io),
    .q_o     (inout_from_pins_o)
  );

endmodule

// ==== src/board_top.sv ====
/*
 * Board I/O shell top level
 * Reset generation, input conditioning, output flops and PMOD pads
 */
`timescale 1ns/1ps

module board_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      pll_locked_i,

  // Board inputs
  input  board_pins_pkg::sw_t       sw_i,
  input  board_pins_pkg::in_pins_t  in_pins_i,

  // From the system core
  input  board_pins_pkg::out_pins_t out_to_pins_i,
  input  board_pins_pkg::out_pins_t out_to_pins_en_i,
  input  sys_io_pkg::gp_out_t       gp_o_i,
  input  sys_io_pkg::spi_cs_t       spi_cs_i,
  input  board_pins_pkg::pmod_t     inout_to_pins_i,
  input  board_pins_pkg::pmod_t     inout_to_pins_en_i,

  output logic                      led_bootok_o,

  // To the system core
  output sys_io_pkg::gp_in_t        gp_i_o,
  output board_pins_pkg::in_pins_t  in_from_pins_o,

  // Board outputs
  output board_pins_pkg::out_pins_t out_pins_o,
  output logic [7:0]                usr_led_o,
  output logic                      lcd_rst_o,
  output logic                      lcd_dc_o,
  output logic                      lcd_backlight_o,
  output logic                      ethmac_rst_o,
  output logic                      appspi_cs_o,
  output logic                      lcd_cs_o,
  output logic                      ethmac_cs_o,

  output board_pins_pkg::pmod_t     inout_from_pins_o,
  inout  wire board_pins_pkg::pmod_t pmod_io
);

  logic rst_sys_n;  // Resets everything below

  rst_ctrl u_rst_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .pll_locked_i (pll_locked_i),
    .rst_sys_n_o  (rst_sys_n)
  );

  assign led_bootok_o = rst_sys_n;  // Lit once the system is out of reset

  in_pinmux u_in_pinmux (
    .clk_i          (clk_i),
    .rst_n_i        (rst_sys_n),
    .sw_i           (sw_i),
    .in_pins_i      (in_pins_i),
    .gp_i_o         (gp_i_o),
    .in_from_pins_o (in_from_pins_o)
  );

  out_pinmux u_out_pinmux (
    .clk_i            (clk_i),
    .rst_n_i          (rst_sys_n),
    .out_to_pins_i    (out_to_pins_i),
    .out_to_pins_en_i (out_to_pins_en_i),
    .gp_o_i           (gp_o_i),
    .spi_cs_i         (spi_cs_i),
    .out_pins_o       (out_pins_o),
    .usr_led_o        (usr_led_o),
    .lcd_rst_o        (lcd_rst_o),
    .lcd_dc_o         (lcd_dc_o),
    .lcd_backlight_o  (lcd_backlight_o),
    .ethmac_rst_o     (ethmac_rst_o),
    .appspi_cs_o      (appspi_cs_o),
    .lcd_cs_o         (lcd_cs_o),
    .ethmac_cs_o      (ethmac_cs_o)
  );

  padring u_padring (
    .clk_i              (clk_i),
    .rst_n_i            (rst_sys_n),
    .inout_to_pins_i    (inout_to_pins_i),
    .inout_to_pins_en_i (inout_to_pins_en_i),
    .inout_from_pins_o  (inout_from_pins_o),
    .pmod_io            (pmod_io)
  );

endmodule

// ==== sim/board_top_asserts.sv ====
/*
 * Concurrent checks on the board I/O shell
 * Chip selects in reset, output gating and boot LED release
 */
`timescale 1ns/1ps

module board_top_asserts (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      pll_locked_i,
  input logic                      rst_sys_n_i,
  input logic                      led_bootok_i,
  input board_pins_pkg::out_pins_t out_to_pins_en_i,
  input board_pins_pkg::out_pins_t out_pins_i,
  input logic                      appspi_cs_i,
  input logic                      lcd_cs_i,
  input logic                      ethmac_cs_i
);

  // No device selected while the system is held in reset
  cs_idle_in_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !rst_sys_n_i |-> (appspi_cs_i && lcd_cs_i && ethmac_cs_i))
    else $error("chip select active while the system is in reset");

  out_gated_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((out_pins_i & ~$past(out_to_pins_en_i)) == '0))  // Disabled pin one cycle later
    else $error("output pin high one cycle after its enable was low");

  boot_needs_lock: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(led_bootok_i) |-> $past(pll_locked_i))
    else $error("boot LED rose without PLL lock on the previous edge");

endmodule

bind board_top board_top_asserts u_board_top_asserts (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .pll_locked_i     (pll_locked_i),
  .rst_sys_n_i      (rst_sys_n),
  .led_bootok_i     (led_bootok_o),
  .out_to_pins_en_i (out_to_pins_en_i),
  .out_pins_i       (out_pins_o),
  .appspi_cs_i      (appspi_cs_o),
  .lcd_cs_i         (lcd_cs_o),
  .ethmac_cs_i      (ethmac_cs_o)
);

// ==== sim/tb_board_top.sv ====
/*
 * Testbench for the board I/O shell
 * Random pin traffic checked against a cycle model of the shell
 */
`timescale 1ns/1ps
`include "sonata_config.svh"

module tb_board_top;

  // Everything the system core and the board drive into the shell
  typedef struct packed {
    board_pins_pkg::sw_t       sw;
    board_pins_pkg::in_pins_t  in_pins;
    board_pins_pkg::out_pins_t out_dat;
    board_pins_pkg::out_pins_t out_en;
    sys_io_pkg::gp_out_t       gp;
    sys_io_pkg::spi_cs_t       cs;
    board_pins_pkg::pmod_t     pmod_dat;
    board_pins_pkg::pmod_t     pmod_en;
    board_pins_pkg::pmod_t     pmod_ext;  // Value put on the header from outside
  } stim_t;

  localparam int RANDOM_CYCLES = 300;
  localparam int BOOT_TIMEOUT  = 400;
  localparam int BOOT_MIN      = 250;
  localparam int BOOT_MAX      = 262;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      pll_locked;
  stim_t                     stim;
  stim_t                     hist [1:3];  // Index is age in cycles at the check point
  board_pins_pkg::pmod_t     pad_drv_en = '1;
  integer                    seed;

  logic                      led_bootok;
  sys_io_pkg::gp_in_t        gp_i;
  board_pins_pkg::in_pins_t  in_from_pins;
  board_pins_pkg::out_pins_t out_pins;
  logic [7:0]                usr_led;
  logic                      lcd_rst;
  logic                      lcd_dc;
  logic                      lcd_backlight;
  logic                      ethmac_rst;
  logic                      appspi_cs;
  logic                      lcd_cs;
  logic                      ethmac_cs;
  board_pins_pkg::pmod_t     inout_from_pins;
  wire board_pins_pkg::pmod_t pmod_io;

  always #2 clk = ~clk;

  // External device drives the pads the shell has released
  always @(posedge clk) pad_drv_en <= ~stim.pmod_en;

  for (genvar i = 0; i < `PMOD_WIDTH; i++) begin : g_ext_pad
    assign pmod_io[i] = pad_drv_en[i] ? stim.pmod_ext[i] : 1'bz;
  end

  board_top u_board_top (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .pll_locked_i       (pll_locked),
    .sw_i               (stim.sw),
    .in_pins_i          (stim.in_pins),
    .out_to_pins_i      (stim.out_dat),
    .out_to_pins_en_i   (stim.out_en),
    .gp_o_i             (stim.gp),
    .spi_cs_i           (stim.cs),
    .inout_to_pins_i    (stim.pmod_dat),
    .inout_to_pins_en_i (stim.pmod_en),
    .led_bootok_o       (led_bootok),
    .gp_i_o             (gp_i),
    .in_from_pins_o     (in_from_pins),
    .out_pins_o         (out_pins),
    .usr_led_o          (usr_led),
    .lcd_rst_o          (lcd_rst),
    .lcd_dc_o           (lcd_dc),
    .lcd_backlight_o    (lcd_backlight),
    .ethmac_rst_o       (ethmac_rst),
    .appspi_cs_o        (appspi_cs),
    .lcd_cs_o           (lcd_cs),
    .ethmac_cs_o        (ethmac_cs),
    .inout_from_pins_o  (inout_from_pins),
    .pmod_io            (pmod_io)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else abort_run($sformatf("Error: %s expected %h got %h", name, exp, act));
  endtask

  // Outputs are stable 1 ns after the edge, before new inputs go out
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive(input stim_t s);
    hist[3] = hist[2];
    hist[2] = hist[1];
    hist[1] = s;
    stim    = s;
  endtask

  task automatic rand_stim(output stim_t s);
    logic [127:0] r;
    r = {$random(seed), $random(seed), $random(seed), $random(seed)};
    s = r[$bits(stim_t)-1:0];
  endtask

  // Inputs that would show up on every output if reset were broken
  function automatic stim_t busy_stim();
    stim_t s;
    s          = '1;
    s.sw       = '0;  // All switches on
    s.cs       = '0;
    s.pmod_en  = '0;
    return s;
  endfunction

  task automatic check_reset_outputs();
    check_val("led_bootok_o", 32'h0, led_bootok);
    check_val("out_pins_o", 32'h0, out_pins);
    check_val("usr_led_o", 32'h0, usr_led);
    check_val("lcd_rst_o", 32'h0, lcd_rst);
    check_val("lcd_dc_o", 32'h0, lcd_dc);
    check_val("lcd_backlight_o", 32'h0, lcd_backlight);
    check_val("ethmac_rst_o", 32'h0, ethmac_rst);
    check_val("appspi_cs_o", 32'h1, appspi_cs);
    check_val("lcd_cs_o", 32'h1, lcd_cs);
    check_val("ethmac_cs_o", 32'h1, ethmac_cs);
    check_val("gp_i_o", 32'h0, gp_i);
    check_val("in_from_pins_o", 32'h0, in_from_pins);
    check_val("inout_from_pins_o", 32'h0, inout_from_pins);
  endtask

  task automatic check_outputs();
    sys_io_pkg::gp_in_t    gp_exp;
    board_pins_pkg::pmod_t pad_exp;
    board_pins_pkg::pmod_t rb_exp;
    gp_exp     = '0;
    gp_exp.sel = ~hist[2].sw.sel;  // Switches read as 1 when on
    gp_exp.usr = ~hist[2].sw.usr;
    gp_exp.nav = ~hist[2].sw.nav;
    pad_exp = (hist[1].pmod_en & hist[1].pmod_dat) | (~hist[1].pmod_en & hist[1].pmod_ext);
    rb_exp  = (hist[3].pmod_en & hist[3].pmod_dat) | (~hist[3].pmod_en & hist[2].pmod_ext);
    check_val("led_bootok_o", 32'h1, led_bootok);
    check_val("out_pins_o", hist[1].out_dat & hist[1].out_en, out_pins);
    check_val("usr_led_o", hist[1].gp.usr_led, usr_led);
    check_val("lcd_rst_o", hist[1].gp.lcd_rst, lcd_rst);
    check_val("lcd_dc_o", hist[1].gp.lcd_dc, lcd_dc);
    check_val("lcd_backlight_o", hist[1].gp.lcd_backlight, lcd_backlight);
    check_val("ethmac_rst_o", hist[1].gp.ethmac_rst, ethmac_rst);
    check_val("appspi_cs_o", hist[1].cs.appspi, appspi_cs);
    check_val("lcd_cs_o", hist[1].cs.lcd, lcd_cs);
    check_val("ethmac_cs_o", hist[1].cs.ethmac, ethmac_cs);
    check_val("gp_i_o", gp_exp, gp_i);
    check_val("in_from_pins_o", hist[2].in_pins, in_from_pins);
    check_val("pmod_io", pad_exp, pmod_io);
    check_val("inout_from_pins_o", rb_exp, inout_from_pins);
  endtask

  // Counts edges from the first one with lock until the boot LED lights
  task automatic wait_boot(output int n);
    n = 0;
    while (led_bootok !== 1'b1) begin
      if (n >= BOOT_TIMEOUT) begin
        abort_run("Boot LED did not light within the reset timeout");
      end
      next_cycle();
      n++;
      if (led_bootok !== 1'b1) check_reset_outputs();
    end
    assert (n >= BOOT_MIN && n <= BOOT_MAX)
      else abort_run($sformatf("Reset released after %0d cycles, outside %0d to %0d",
                               n, BOOT_MIN, BOOT_MAX));
  endtask

  initial begin
    int    n;
    stim_t s;
    seed       = 32'h8da61160;
    rst_n      = 1'b0;
    pll_locked = 1'b0;
    drive(busy_stim());
    repeat (16) begin
      next_cycle();
      check_reset_outputs();
    end
    rst_n = 1'b1;
    repeat (4) begin
      next_cycle();
      check_reset_outputs();
    end
    pll_locked = 1'b1;  // Cycle 20
    wait_boot(n);

    // Fill the history before the model is trusted
    repeat (3) begin
      rand_stim(s);
      drive(s);
      next_cycle();
    end
    repeat (RANDOM_CYCLES) begin
      check_outputs();
      rand_stim(s);
      drive(s);
      next_cycle();
    end

    // Release the pads, then pulse the lock low
    drive(busy_stim());
    next_cycle();
    pll_locked = 1'b0;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (led_bootok === 1'b1 && n < 2);
    assert (led_bootok === 1'b0)
      else abort_run("Boot LED still lit two edges after the PLL lost lock");
    next_cycle();
    pll_locked = 1'b1;
    wait_boot(n);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/board_pins_pkg.sv
src/sys_io_pkg.sv
src/rst_ctrl.sv
src/pin_sync.sv
src/in_pinmux.sv
src/out_pinmux.sv
src/padring.sv
src/board_top.sv
sim/board_top_asserts.sv
sim/tb_board_top.sv

// ==== Bender.yml ====
package:
  name: board_io_shell

sources:
  - include_dirs:
      - src
    files:
      - src/board_pins_pkg.sv
      - src/sys_io_pkg.sv
      - src/rst_ctrl.sv
      - src/pin_sync.sv
      - src/in_pinmux.sv
      - src/out_pinmux.sv
      - src/padring.sv
      - src/board_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/board_top_asserts.sv
      - sim/tb_board_top.sv
